//--- src.f
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/ctrlBus.sv
verilog/controlFsm.sv
verilog/pcUnit.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/execUnit.sv
verilog/cpuTop.sv
sim/cpuTop_assert.sv
sim/cpuTop_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTop_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

//--- sim/cpuTop_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tbClock #(
  parameter int periodNs = 100
) (
  output logic clk
);

  always begin
    clk = 1'b0;
    #(periodNs / 2);
    clk = 1'b1;
    #(periodNs / 2);
  end

endmodule

module cpuTop_tb;

  localparam int periodNs = 100;
  // Instruction count padded for gaps and drains
  localparam int instrBudget = 48;
  localparam int timeoutNs = instrBudget * 4 * periodNs + 20 * periodNs;

  typedef struct packed {
    logic        isExc;
    logic [1:0]  cause;
    logic [4:0]  wbReg;
    logic        writes;
    logic [31:0] wbData;
    logic [31:0] pc;
    logic [31:0] epc;
  } expT;

  logic              clk;
  logic              reset;
  logic              instrValid;
  logic [31:0]       instr;
  logic              instrReady;
  logic              wbValid;
  logic [4:0]        wbReg;
  logic [31:0]       wbData;
  logic              excValid;
  ctrlPkg::excCauseT excCause;
  logic [31:0]       epc;
  logic [31:0]       pc;

  logic [31:0] lfsr;
  logic [31:0] modelRegs [32];
  logic [31:0] modelPc;
  expT         expQ [$];
  expT         curExp;
  logic        pcCheckPending;
  string       testName;
  int          errorCount;
  int          checkCount;
  int          testCount;
  int          failedTests;
  int          testErrBase;

  tbClock #(.periodNs(periodNs)) clockGen (.clk(clk));

  cpuTop cpuTop_inst (
    .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
    .instrReady(instrReady), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .excValid(excValid), .excCause(excCause), .epc(epc), .pc(pc)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [5:0] funct);
    return {6'b000000, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  // Model of one instruction that updates the model registers and PC
  function automatic expT refStep(input logic [31:0] word);
    expT         e;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [31:0] pcPlus4;
    logic [31:0] newPc;
    logic [4:0]  dst;
    logic        ovf;
    logic        bad;
    logic        writes;
    longint      sum;
    a       = modelRegs[word[25:21]];
    b       = modelRegs[word[20:16]];
    imm     = {{16{word[15]}}, word[15:0]};
    pcPlus4 = modelPc + 32'd4;
    newPc   = pcPlus4;
    e       = '0;
    res     = '0;
    dst     = word[15:11];
    ovf     = 1'b0;
    bad     = 1'b0;
    writes  = 1'b1;
    sum     = 0;
    case (word[31:26])
      isaPkg::opRType: begin
        case (word[5:0])
          isaPkg::fnAdd: begin
            sum = longint'($signed(a)) + longint'($signed(b));
            res = sum[31:0];
            ovf = (sum != longint'($signed(res)));
          end
          isaPkg::fnSub: begin
            sum = longint'($signed(a)) - longint'($signed(b));
            res = sum[31:0];
            ovf = (sum != longint'($signed(res)));
          end
          isaPkg::fnAnd: res = a & b;
          isaPkg::fnSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: bad = 1'b1;
        endcase
      end
      isaPkg::opAddi: begin
        dst = word[20:16];
        sum = longint'($signed(a)) + longint'($signed(imm));
        res = sum[31:0];
        ovf = (sum != longint'($signed(res)));
      end
      isaPkg::opAddiu: begin
        dst = word[20:16];
        res = a + imm;
      end
      isaPkg::opSlti: begin
        dst = word[20:16];
        res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
      end
      isaPkg::opLui: begin
        dst = word[20:16];
        res = {word[15:0], 16'h0000};
      end
      isaPkg::opJ: begin
        dst    = 5'd0;
        writes = 1'b0;
        newPc  = {pcPlus4[31:28], word[25:0], 2'b00};
      end
      isaPkg::opJal: begin
        dst   = 5'(`CPU_LINK_REG);
        res   = pcPlus4;
        newPc = {pcPlus4[31:28], word[25:0], 2'b00};
      end
      default: bad = 1'b1;
    endcase
    if (bad || ovf) begin
      e.isExc = 1'b1;
      e.cause = bad ? ctrlPkg::excIllegal : ctrlPkg::excOverflow;
      e.epc   = modelPc;
      modelPc = `CPU_EXC_VECTOR;
    end else begin
      e.wbReg  = dst;
      e.writes = writes;
      e.wbData = res;
      if (writes && dst != 5'd0) begin
        modelRegs[dst] = res;
      end
      modelPc = newPc;
    end
    e.pc = modelPc;
    return e;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    checkCount++;
    if (expVal !== actVal) begin
      errorCount++;
      $display("FAILED %s %s: expected %h actual %h", testName, what, expVal, actVal);
    end
  endtask

  task automatic reportError(input string msg);
    errorCount++;
    $display("ERROR in %s: %s", testName, msg);
  endtask

  task automatic issue(input logic [31:0] word);
    expQ.push_back(refStep(word));
    @(posedge clk);
    #1;
    instrValid = 1'b1;
    instr      = word;
    do begin
      @(negedge clk);
    end while (!instrReady);
    @(posedge clk);
    #1;
    instrValid = 1'b0;
  endtask

  task automatic waitIdle();
    while (expQ.size() != 0 || pcCheckPending) begin
      @(negedge clk);
    end
  endtask

  task automatic startTest(input string name);
    testName    = name;
    testErrBase = errorCount;
  endtask

  task automatic finishTest();
    waitIdle();
    testCount++;
    if (errorCount != testErrBase) begin
      failedTests++;
      $display("test %-28s FAIL (%0d errors)", testName, errorCount - testErrBase);
    end else begin
      $display("test %-28s ok", testName);
    end
  endtask

  // Compare against the model at mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (pcCheckPending) begin
        pcCheckPending = 1'b0;
        checkValue("pc", curExp.pc, pc);
        if (curExp.isExc) begin
          checkValue("epc", curExp.epc, epc);
        end
      end
      if (wbValid || excValid) begin
        if (expQ.size() == 0) begin
          reportError("DUT reported a result with no instruction outstanding");
        end else begin
          curExp         = expQ.pop_front();
          pcCheckPending = 1'b1;
          if (curExp.isExc && !excValid) begin
            reportError("writeback seen where an exception was expected");
          end
          if (!curExp.isExc && !wbValid) begin
            reportError("exception seen where a writeback was expected");
          end
          if (wbValid && !curExp.isExc) begin
            checkValue("wbReg", 32'(curExp.wbReg), 32'(wbReg));
            if (curExp.writes) begin
              checkValue("wbData", curExp.wbData, wbData);
            end
          end
          if (excValid && curExp.isExc) begin
            checkValue("excCause", 32'(curExp.cause), 32'(excCause));
          end
        end
      end
    end
  end

  initial begin
    #(timeoutNs);
    $display("Watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int          n;
    int          k;
    int          gap;
    logic [31:0] word;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    logic [1:0]  sel;
    lfsr           = 32'd11;
    reset          = 1'b1;
    instrValid     = 1'b0;
    instr          = '0;
    pcCheckPending = 1'b0;
    errorCount     = 0;
    checkCount     = 0;
    testCount      = 0;
    failedTests    = 0;
    testErrBase    = 0;
    testName       = "reset";
    modelPc        = `CPU_RESET_PC;
    for (k = 0; k < 32; k++) begin
      modelRegs[k] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    startTest("reset and first instruction");
    @(negedge clk);
    checkValue("pc after reset", `CPU_RESET_PC, pc);
    checkValue("epc after reset", 32'd0, epc);
    imm = 16'(randBits(16));
    issue(encI(isaPkg::opAddi, 5'd0, 5'd1, imm));
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wbValid && n < 8);
    checkValue("wbValid delay", 32'd3, 32'(n));
    finishTest();

    startTest("immediate and R-type mix");
    for (k = 0; k < 8; k++) begin
      sel = 2'(randBits(2));
      rs  = 5'(randBits(3));
      rt  = 5'(randBits(3));
      imm = 16'(randBits(16));
      case (sel)
        2'd0: word = encI(isaPkg::opAddi, rs, rt, imm);
        2'd1: word = encI(isaPkg::opAddiu, rs, rt, imm);
        2'd2: word = encI(isaPkg::opLui, rs, rt, imm);
        default: word = encI(isaPkg::opSlti, rs, rt, imm);
      endcase
      issue(word);
    end
    for (k = 0; k < 8; k++) begin
      sel = 2'(randBits(2));
      rs  = 5'(randBits(3));
      rt  = 5'(randBits(3));
      rd  = 5'(randBits(3));
      case (sel)
        2'd0: word = encR(rs, rt, rd, isaPkg::fnAdd);
        2'd1: word = encR(rs, rt, rd, isaPkg::fnSub);
        2'd2: word = encR(rs, rt, rd, isaPkg::fnAnd);
        default: word = encR(rs, rt, rd, isaPkg::fnSlt);
      endcase
      issue(word);
    end
    // r0 must still read zero
    issue(encI(isaPkg::opAddi, 5'd0, 5'd0, 16'h1234));
    issue(encR(5'd0, 5'd0, 5'd5, isaPkg::fnAdd));
    finishTest();

    startTest("j and jal");
    issue(encJ(isaPkg::opJ, 26'(randBits(26))));
    issue(encJ(isaPkg::opJal, 26'(randBits(26))));
    issue(encR(5'd31, 5'd0, 5'd6, isaPkg::fnAdd));
    finishTest();

    startTest("overflow traps");
    issue(encI(isaPkg::opLui, 5'd0, 5'd1, 16'h7fff));
    issue(encI(isaPkg::opAddiu, 5'd1, 5'd1, 16'h7fff));
    issue(encI(isaPkg::opAddiu, 5'd1, 5'd1, 16'h7fff));
    issue(encI(isaPkg::opAddi, 5'd1, 5'd2, 16'h0010));
    issue(encI(isaPkg::opAddiu, 5'd1, 5'd2, 16'h0010));
    issue(encR(5'd1, 5'd1, 5'd3, isaPkg::fnAdd));
    issue(encI(isaPkg::opLui, 5'd0, 5'd4, 16'h8000));
    issue(encR(5'd4, 5'd1, 5'd3, isaPkg::fnSub));
    finishTest();

    startTest("illegal opcode and funct");
    issue(encI(6'b111111, 5'd1, 5'd2, 16'h0001));
    issue(encR(5'd1, 5'd2, 5'd3, 6'b000111));
    issue(encI(6'b000100, 5'd1, 5'd2, 16'h0004));
    finishTest();

    startTest("idle gaps");
    for (k = 0; k < 4; k++) begin
      rt  = 5'(randBits(3));
      imm = 16'(randBits(16));
      issue(encI(isaPkg::opAddiu, rt, rt, imm));
      waitIdle();
      gap = int'(randBits(2)) + 1;
      repeat (gap) begin
        @(negedge clk);
        if (!instrReady) begin
          reportError("instrReady low while the core was idle");
        end
        if (wbValid) begin
          reportError("wbValid while no instruction was sent");
        end
        checkValue("pc in gap", modelPc, pc);
        checkValue("wbData in gap", curExp.wbData, wbData);
      end
    end
    finishTest();

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- sim/cpuTop_assert.sv
`timescale 1ns/1ps

module cpuTop_assert (
  input logic clk,
  input logic reset,
  input logic instrValid,
  input logic instrReady,
  input logic wbValid,
  input logic excValid
);

  wbExcExclusive: assert property (
    @(posedge clk) disable iff (reset) !(wbValid && excValid)
  ) else $error("wbValid and excValid high in the same cycle");

  // Core is busy for three cycles after it takes an instruction
  readyDropsAfterHandshake: assert property (
    @(posedge clk) disable iff (reset) (instrValid && instrReady) |=> !instrReady
  ) else $error("instrReady high in the cycle after a handshake");

  wbThreeAfterHandshake: assert property (
    @(posedge clk) disable iff (reset) wbValid |-> $past(instrValid && instrReady, 3)
  ) else $error("wbValid not 3 cycles after a handshake");

endmodule

bind cpuTop cpuTop_assert cpuTopAssertInst (
  .clk(clk), .reset(reset), .instrValid(instrValid), .instrReady(instrReady),
  .wbValid(wbValid), .excValid(excValid)
);

//--- verilog/cpuTop.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpuTop (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 instrValid,
  input  logic [`CPU_XLEN-1:0] instr,
  output logic                 instrReady,
  output logic                 wbValid,
  output logic [4:0]           wbReg,
  output logic [`CPU_XLEN-1:0] wbData,
  output logic                 excValid,
  output ctrlPkg::excCauseT    excCause,
  output logic [`CPU_XLEN-1:0] epc,
  output logic [`CPU_XLEN-1:0] pc
);

  isaPkg::decodedT      decoded;
  logic                 overflow;
  logic [`CPU_XLEN-1:0] result;
  logic [`CPU_XLEN-1:0] rsData;
  logic [`CPU_XLEN-1:0] rtData;

  ctrlBus ctrlBusInst ();

  assign wbReg = decoded.rd;

  controlFsm controlFsmInst (
    .clk(clk), .reset(reset), .instrValid(instrValid), .decoded(decoded),
    .overflow(overflow), .ctrl(ctrlBusInst.fsm), .instrReady(instrReady),
    .wbValid(wbValid), .excValid(excValid), .excCause(excCause)
  );

  pcUnit pcUnitInst (
    .clk(clk), .reset(reset), .ctrl(ctrlBusInst.pcSide), .decoded(decoded),
    .pc(pc), .epc(epc)
  );

  instrDecoder instrDecoderInst (
    .clk(clk), .reset(reset), .irWrite(ctrlBusInst.irWrite), .instr(instr),
    .decoded(decoded)
  );

  regFile regFileInst (
    .clk(clk), .reset(reset), .ctrl(ctrlBusInst.rfSide), .decoded(decoded),
    .result(result), .pc(pc), .rsData(rsData), .rtData(rtData), .wbData(wbData)
  );

  execUnit execUnitInst (
    .clk(clk), .reset(reset), .ctrl(ctrlBusInst.execSide), .decoded(decoded),
    .rsData(rsData), .rtData(rtData), .result(result), .overflow(overflow)
  );

endmodule

//--- verilog/execUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execUnit (
  input  logic                 clk,
  input  logic                 reset,
  ctrlBus.execSide             ctrl,
  input  isaPkg::decodedT      decoded,
  input  logic [`CPU_XLEN-1:0] rsData,
  input  logic [`CPU_XLEN-1:0] rtData,
  output logic [`CPU_XLEN-1:0] result,
  output logic                 overflow
);

  localparam int msb = `CPU_XLEN - 1;

  logic [`CPU_XLEN-1:0] aReg;
  logic [`CPU_XLEN-1:0] bReg;
  logic [`CPU_XLEN-1:0] opB;
  logic [`CPU_XLEN-1:0] aluOut;
  logic                 aluOvf;

  assign opB = decoded.useImm ? decoded.imm : bReg;

  always_comb begin
    aluOvf = 1'b0;
    case (decoded.aluOp)
      isaPkg::aluAdd: begin
        aluOut = aReg + opB;
        aluOvf = (aReg[msb] == opB[msb]) && (aluOut[msb] != aReg[msb]);
      end
      isaPkg::aluSub: begin
        aluOut = aReg - opB;
        aluOvf = (aReg[msb] != opB[msb]) && (aluOut[msb] != aReg[msb]);
      end
      isaPkg::aluAnd: aluOut = aReg & opB;
      isaPkg::aluSlt: aluOut = `CPU_XLEN'($signed(aReg) < $signed(opB));
      // lui
      isaPkg::aluPassImm: aluOut = opB << 16;
      default: aluOut = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.operandWrite) begin
      aReg <= rsData;
      bReg <= rtData;
    end
    if (ctrl.resultWrite) begin
      result <= aluOut;
    end
  end

  // Only trapping instructions raise the flag
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else if (ctrl.resultWrite) begin
      overflow <= aluOvf && decoded.trapsOverflow;
    end
  end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regFile (
  input  logic                 clk,
  input  logic                 reset,
  ctrlBus.rfSide               ctrl,
  input  isaPkg::decodedT      decoded,
  input  logic [`CPU_XLEN-1:0] result,
  input  logic [`CPU_XLEN-1:0] pc,
  output logic [`CPU_XLEN-1:0] rsData,
  output logic [`CPU_XLEN-1:0] rtData,
  output logic [`CPU_XLEN-1:0] wbData
);

  logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

  // Link value is the PC after fetch stepped it
  assign wbData = (ctrl.wbSel == ctrlPkg::wbLink) ? pc : result;
  assign rsData = regs[decoded.rs];
  assign rtData = regs[decoded.rt];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.regWrite && (decoded.rd != '0)) begin
      regs[decoded.rd] <= wbData;
    end
  end

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module instrDecoder (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 irWrite,
  input  logic [`CPU_XLEN-1:0] instr,
  output isaPkg::decodedT      decoded
);

  logic [`CPU_XLEN-1:0] instrReg;

  always_ff @(posedge clk) begin
    if (reset) begin
      instrReg <= '0;
    end else if (irWrite) begin
      instrReg <= instr;
    end
  end

  always_comb begin
    decoded               = '0;
    decoded.rs            = instrReg[25:21];
    decoded.rt            = instrReg[20:16];
    decoded.rd            = instrReg[15:11];
    decoded.imm           = {{(`CPU_XLEN-16){instrReg[15]}}, instrReg[15:0]};
    decoded.target        = instrReg[25:0];
    decoded.aluOp         = isaPkg::aluAdd;
    case (instrReg[31:26])
      isaPkg::opRType: begin
        decoded.writesReg = 1'b1;
        case (instrReg[5:0])
          isaPkg::fnAdd: decoded.trapsOverflow = 1'b1;
          isaPkg::fnSub: begin
            decoded.aluOp         = isaPkg::aluSub;
            decoded.trapsOverflow = 1'b1;
          end
          isaPkg::fnAnd: decoded.aluOp = isaPkg::aluAnd;
          isaPkg::fnSlt: decoded.aluOp = isaPkg::aluSlt;
          default: begin
            decoded.writesReg = 1'b0;
            decoded.illegal   = 1'b1;
          end
        endcase
      end
      isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opLui: begin
        // Immediates write rt
        decoded.rd            = instrReg[20:16];
        decoded.useImm        = 1'b1;
        decoded.writesReg     = 1'b1;
        decoded.trapsOverflow = (instrReg[31:26] == isaPkg::opAddi);
        if (instrReg[31:26] == isaPkg::opSlti) begin
          decoded.aluOp = isaPkg::aluSlt;
        end else if (instrReg[31:26] == isaPkg::opLui) begin
          decoded.aluOp = isaPkg::aluPassImm;
        end
      end
      isaPkg::opJ: begin
        decoded.rd     = '0;
        decoded.isJump = 1'b1;
      end
      isaPkg::opJal: begin
        decoded.rd        = 5'(`CPU_LINK_REG);
        decoded.isJump    = 1'b1;
        decoded.isLink    = 1'b1;
        decoded.writesReg = 1'b1;
      end
      default: decoded.illegal = 1'b1;
    endcase
  end

endmodule

//--- verilog/pcUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pcUnit (
  input  logic                 clk,
  input  logic                 reset,
  ctrlBus.pcSide               ctrl,
  input  isaPkg::decodedT      decoded,
  output logic [`CPU_XLEN-1:0] pc,
  output logic [`CPU_XLEN-1:0] epc
);

  logic [`CPU_XLEN-1:0] pcNextVal;

  always_comb begin
    case (ctrl.pcSel)
      // Region bits kept from the already stepped PC
      ctrlPkg::pcJump: begin
        pcNextVal = {pc[`CPU_XLEN-1:`CPU_XLEN-4], decoded.target, 2'b00};
      end
      ctrlPkg::pcVector: begin
        pcNextVal = `CPU_EXC_VECTOR;
      end
      default: begin
        pcNextVal = pc + `CPU_XLEN'(4);
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc  <= `CPU_RESET_PC;
      epc <= '0;
    end else begin
      if (ctrl.pcWrite) begin
        pc <= pcNextVal;
      end
      // PC already points past the faulting instruction
      if (ctrl.epcWrite) begin
        epc <= pc - `CPU_XLEN'(4);
      end
    end
  end

endmodule

//--- verilog/controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
  input  logic              clk,
  input  logic              reset,
  input  logic              instrValid,
  input  isaPkg::decodedT   decoded,
  input  logic              overflow,
  ctrlBus.fsm               ctrl,
  output logic              instrReady,
  output logic              wbValid,
  output logic              excValid,
  output ctrlPkg::excCauseT excCause
);

  ctrlPkg::stateT state;
  ctrlPkg::stateT stateNext;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ctrlPkg::stFetch;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext         = state;
    ctrl.irWrite      = 1'b0;
    ctrl.pcWrite      = 1'b0;
    ctrl.pcSel        = ctrlPkg::pcNext;
    ctrl.epcWrite     = 1'b0;
    ctrl.operandWrite = 1'b0;
    ctrl.resultWrite  = 1'b0;
    ctrl.regWrite     = 1'b0;
    ctrl.wbSel        = decoded.isLink ? ctrlPkg::wbLink : ctrlPkg::wbAlu;
    instrReady        = 1'b0;
    wbValid           = 1'b0;
    excValid          = 1'b0;
    excCause          = ctrlPkg::excNone;
    case (state)
      ctrlPkg::stFetch: begin
        instrReady = 1'b1;
        // Load IR and step PC on the handshake
        if (instrValid) begin
          ctrl.irWrite = 1'b1;
          ctrl.pcWrite = 1'b1;
          stateNext    = ctrlPkg::stDecode;
        end
      end
      ctrlPkg::stDecode: begin
        ctrl.operandWrite = 1'b1;
        stateNext = decoded.illegal ? ctrlPkg::stException : ctrlPkg::stExecute;
      end
      ctrlPkg::stExecute: begin
        ctrl.resultWrite = 1'b1;
        stateNext        = ctrlPkg::stWriteback;
      end
      ctrlPkg::stWriteback: begin
        if (overflow) begin
          stateNext = ctrlPkg::stException;
        end else begin
          wbValid       = 1'b1;
          ctrl.regWrite = decoded.writesReg;
          ctrl.pcWrite  = decoded.isJump;
          ctrl.pcSel    = ctrlPkg::pcJump;
          stateNext     = ctrlPkg::stFetch;
        end
      end
      ctrlPkg::stException: begin
        excValid      = 1'b1;
        excCause      = decoded.illegal ? ctrlPkg::excIllegal : ctrlPkg::excOverflow;
        ctrl.epcWrite = 1'b1;
        ctrl.pcWrite  = 1'b1;
        ctrl.pcSel    = ctrlPkg::pcVector;
        stateNext     = ctrlPkg::stFetch;
      end
      default: stateNext = ctrlPkg::stFetch;
    endcase
  end

endmodule

//--- verilog/ctrlBus.sv
`timescale 1ns/1ps

interface ctrlBus;

  logic            irWrite;
  logic            pcWrite;
  ctrlPkg::pcSelT  pcSel;
  logic            epcWrite;
  logic            operandWrite;
  logic            resultWrite;
  logic            regWrite;
  ctrlPkg::wbSelT  wbSel;

  modport fsm (
    output irWrite, pcWrite, pcSel, epcWrite,
    output operandWrite, resultWrite, regWrite, wbSel
  );

  modport pcSide (input pcWrite, pcSel, epcWrite);

  modport execSide (input operandWrite, resultWrite);

  modport rfSide (input regWrite, wbSel);

endinterface

//--- verilog/ctrlPkg.sv
package ctrlPkg;

  typedef enum logic [2:0] {
    stFetch,
    stDecode,
    stExecute,
    stWriteback,
    stException
  } stateT;

  typedef enum logic [1:0] {
    pcNext,
    pcJump,
    pcVector
  } pcSelT;

  typedef enum logic {
    wbAlu,
    wbLink
  } wbSelT;

  typedef enum logic [1:0] {
    excNone,
    excOverflow,
    excIllegal
  } excCauseT;

endpackage

//--- verilog/isaPkg.sv
`include "cpu_macros.svh"

package isaPkg;

  typedef enum logic [5:0] {
    opRType = 6'b000000,
    opJ     = 6'b000010,
    opJal   = 6'b000011,
    opAddi  = 6'b001000,
    opAddiu = 6'b001001,
    opSlti  = 6'b001010,
    opLui   = 6'b001111
  } opcodeT;

  typedef enum logic [5:0] {
    fnAdd = 6'b100000,
    fnSub = 6'b100010,
    fnAnd = 6'b100100,
    fnSlt = 6'b101010
  } functT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluSlt,
    aluPassImm
  } aluOpT;

  // Fields pulled out of the instruction register
  typedef struct packed {
    logic [4:0]           rs;
    logic [4:0]           rt;
    logic [4:0]           rd;
    logic [`CPU_XLEN-1:0] imm;
    logic [25:0]          target;
    aluOpT                aluOp;
    logic                 useImm;
    logic                 trapsOverflow;
    logic                 isJump;
    logic                 isLink;
    logic                 writesReg;
    logic                 illegal;
  } decodedT;

endpackage

//--- verilog/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Core widths and sizes
`define CPU_XLEN 32
`define CPU_REG_COUNT 32

// Fixed addresses
`define CPU_RESET_PC 32'h0000_0000
`define CPU_EXC_VECTOR 32'h8000_0180
`define CPU_LINK_REG 31

`endif
